// File: Bender.yml
package:
  name: lsq_top

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/lsq_pkg.sv
      - queue/store_queue.sv
      - queue/load_station.sv
      - mem_access/mem_access_unit.sv
      - source/lsq_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - verification/lsq_tb.sv

// File: common/lsq_cfg.svh
`ifndef LSQ_CFG_SVH
`define LSQ_CFG_SVH

// entries in the store queue and in the load station
// must stay a power of two so the ring pointers wrap on their own
`define LSQ_DEPTH 8

// reorder buffer size, sets the tag width
`define ROB_DEPTH 8

// data and address width
`define XLEN 32

// byte lanes on the memory port
`define LSQ_LANES (`XLEN / 8)

`endif

// File: common/lsq_pkg.sv
`default_nettype none

`include "lsq_cfg.svh"

package lsq_pkg;

    localparam int LSQ_IDX_W = $clog2(`LSQ_DEPTH);
    localparam int ROB_TAG_W = $clog2(`ROB_DEPTH);

    typedef logic [LSQ_IDX_W-1:0] lsq_idx_t;
    typedef logic [ROB_TAG_W-1:0] rob_tag_t;

    // rv32 major opcodes seen by the queues
    typedef enum logic [6:0] {
        op_load  = 7'b0000011,
        op_store = 7'b0100011
    } rv_opcode_e;

    typedef enum logic [2:0] {
        lb  = 3'b000,
        lh  = 3'b001,
        lw  = 3'b010,
        lbu = 3'b100,
        lhu = 3'b101
    } load_f3_e;

    typedef enum logic [2:0] {
        sb = 3'b000,
        sh = 3'b001,
        sw = 3'b010
    } store_f3_e;

    typedef enum logic [2:0] {
        IDLE,
        LOAD,
        STORE,
        DONE,
        STORE_DONE
    } mem_state_e;

    typedef struct packed {
        logic              valid;
        logic [`XLEN-1:0]  instr;
        rob_tag_t          tag;
    } dispatch_t;

    // address from the agu, store data from the rs
    typedef struct packed {
        logic              valid;
        logic [`XLEN-1:0]  addr;
        logic [`XLEN-1:0]  data;
        rob_tag_t          tag;
    } addr_update_t;

    // access offered by a queue to the memory unit
    typedef struct packed {
        logic              valid;
        logic [`XLEN-1:0]  addr;
        logic [`XLEN-1:0]  data;
        logic [2:0]        funct3;
        rob_tag_t          tag;
    } mem_op_t;

    typedef struct packed {
        logic [`XLEN-1:0]      addr;
        logic [`LSQ_LANES-1:0] rmask;
        logic [`LSQ_LANES-1:0] wmask;
        logic [`XLEN-1:0]      wdata;
    } mem_req_t;

    typedef struct packed {
        logic              valid;
        logic [`XLEN-1:0]  data;
        rob_tag_t          tag;
    } cdb_t;

    typedef struct packed {
        logic      nonempty;
        lsq_idx_t  youngest;
        logic      commit;
        lsq_idx_t  committed;
    } sq_status_t;

endpackage

`default_nettype wire

// File: lsq_top.f
+incdir+common
common/lsq_pkg.sv
queue/store_queue.sv
queue/load_station.sv
mem_access/mem_access_unit.sv
source/lsq_top.sv
verification/lsq_tb.sv

// File: mem_access/mem_access_unit.sv
`default_nettype none

`include "lsq_cfg.svh"

module mem_access_unit
    import lsq_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              flush,
    input  mem_op_t           store_cand,
    input  mem_op_t           load_cand,
    input  logic [`XLEN-1:0]  mem_rdata,
    input  logic              mem_resp,
    output mem_req_t          mem_req,
    output cdb_t              cdb,
    output logic              store_done,
    output logic              load_done
);

    mem_state_e        state;
    mem_state_e        state_next;
    mem_op_t           cur_op;
    logic [`XLEN-1:0]  load_data;
    logic              flush_pending;
    logic              issue_store;
    logic              issue_load;
    logic [1:0]        store_off;
    logic [1:0]        load_off;

    // pick the addressed lane, then sign or zero extend
    function automatic logic [`XLEN-1:0] extend_load(
        input logic [2:0]        f3,
        input logic [1:0]        off,
        input logic [`XLEN-1:0]  raw
    );
        logic [7:0]  b;
        logic [15:0] h;
        b = raw[8*off +: 8];
        h = raw[16*off[1] +: 16];
        case (load_f3_e'(f3))
            lb:      return {{(`XLEN-8){b[7]}}, b};
            lbu:     return {{(`XLEN-8){1'b0}}, b};
            lh:      return {{(`XLEN-16){h[15]}}, h};
            lhu:     return {{(`XLEN-16){1'b0}}, h};
            default: return raw;
        endcase
    endfunction

    assign store_off = store_cand.addr[1:0];
    assign load_off  = load_cand.addr[1:0];

    // stores win, nothing new while a flushed access is still out
    assign issue_store = (state == IDLE) && !flush_pending && store_cand.valid;
    assign issue_load  = (state == IDLE) && !flush_pending && !store_cand.valid &&
                         load_cand.valid;

    assign store_done = (state == STORE) && mem_resp;
    assign load_done  = (state == LOAD) && mem_resp;

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (issue_store) begin
                    state_next = STORE;
                end else if (issue_load) begin
                    state_next = LOAD;
                end
            end
            LOAD:       if (mem_resp) state_next = DONE;
            STORE:      if (mem_resp) state_next = STORE_DONE;
            DONE:       state_next = IDLE;
            STORE_DONE: state_next = IDLE;
            default:    state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    // a response still owed after flush must be swallowed
    always_ff @(posedge clk) begin
        if (rst) begin
            flush_pending <= 1'b0;
        end else if (flush_pending) begin
            if (mem_resp) begin
                flush_pending <= 1'b0;
            end
        end else if (flush) begin
            flush_pending <= issue_store || issue_load ||
                             (((state == LOAD) || (state == STORE)) && !mem_resp);
        end
    end

    always_ff @(posedge clk) begin
        if (issue_store) begin
            cur_op <= store_cand;
        end else if (issue_load) begin
            cur_op <= load_cand;
        end
        if (load_done) begin
            load_data <= extend_load(cur_op.funct3, cur_op.addr[1:0], mem_rdata);
        end
    end

    // request lives for the issue cycle only
    always_comb begin
        mem_req = '0;
        if (issue_store) begin
            mem_req.addr = store_cand.addr;
            case (store_f3_e'(store_cand.funct3))
                sb: begin
                    mem_req.wmask = 4'b0001 << store_off;
                    mem_req.wdata[8*store_off +: 8] = store_cand.data[7:0];
                end
                sh: begin
                    mem_req.wmask = 4'b0011 << store_off;
                    mem_req.wdata[16*store_off[1] +: 16] = store_cand.data[15:0];
                end
                default: begin
                    mem_req.wmask = 4'b1111;
                    mem_req.wdata = store_cand.data;
                end
            endcase
        end else if (issue_load) begin
            mem_req.addr = load_cand.addr;
            case (load_f3_e'(load_cand.funct3))
                lb, lbu: mem_req.rmask = 4'b0001 << load_off;
                lh, lhu: mem_req.rmask = 4'b0011 << load_off;
                default: mem_req.rmask = 4'b1111;
            endcase
        end
    end

    // stores report at the response, loads one cycle later
    always_comb begin
        cdb = '0;
        if (store_done) begin
            cdb.valid = 1'b1;
            cdb.tag   = cur_op.tag;
        end else if (state == DONE) begin
            cdb.valid = 1'b1;
            cdb.data  = load_data;
            cdb.tag   = cur_op.tag;
        end
    end

endmodule

`default_nettype wire

// File: queue/load_station.sv
`default_nettype none

`include "lsq_cfg.svh"

module load_station
    import lsq_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  logic          flush,
    input  dispatch_t     dispatch,
    input  addr_update_t  addr_update,
    input  sq_status_t    sq_status,
    input  logic          load_done,
    output logic          full,
    output mem_op_t       load_cand
);

    logic [`LSQ_DEPTH-1:0] valid_q;
    logic [`LSQ_DEPTH-1:0] ready_q;
    logic [`LSQ_DEPTH-1:0] dep_valid_q;
    lsq_idx_t              dep_ptr_q [`LSQ_DEPTH];
    logic [2:0]            funct3_q  [`LSQ_DEPTH];
    rob_tag_t              tag_q     [`LSQ_DEPTH];
    logic [`XLEN-1:0]      addr_q    [`LSQ_DEPTH];
    logic [`LSQ_DEPTH-1:0] issuable;
    lsq_idx_t              free_idx;
    lsq_idx_t              found_idx;
    logic                  found;
    logic                  push;
    logic                  dep_at_push;
    logic                  retire;
    logic                  sel_valid;
    lsq_idx_t              sel_idx;
    lsq_idx_t              rr_base;

    assign full = &valid_q;
    assign push = dispatch.valid && (dispatch.instr[6:0] == op_load) && !full;

    // a youngest store that commits right now no longer blocks the load
    assign dep_at_push = sq_status.nonempty &&
        !(sq_status.commit && (sq_status.committed == sq_status.youngest));

    // lowest free slot
    always_comb begin
        free_idx = '0;
        for (int i = `LSQ_DEPTH - 1; i >= 0; i--) begin
            if (!valid_q[i]) begin
                free_idx = lsq_idx_t'(i);
            end
        end
    end

    always_comb begin
        for (int i = 0; i < `LSQ_DEPTH; i++) begin
            issuable[i] = valid_q[i] && ready_q[i] && !dep_valid_q[i];
        end
    end

    // round robin from one past the last finished load
    always_comb begin
        lsq_idx_t idx;
        found     = 1'b0;
        found_idx = rr_base;
        for (int i = 0; i < `LSQ_DEPTH; i++) begin
            idx = rr_base + lsq_idx_t'(i);
            if (!found && issuable[idx]) begin
                found     = 1'b1;
                found_idx = idx;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            valid_q     <= '0;
            dep_valid_q <= '0;
            sel_valid   <= 1'b0;
            sel_idx     <= '0;
            rr_base     <= '0;
            retire      <= 1'b0;
        end else begin
            retire <= load_done;
            if (sq_status.commit) begin
                for (int i = 0; i < `LSQ_DEPTH; i++) begin
                    if (dep_ptr_q[i] == sq_status.committed) begin
                        dep_valid_q[i] <= 1'b0;
                    end
                end
            end
            if (push) begin
                valid_q[free_idx]     <= 1'b1;
                dep_valid_q[free_idx] <= dep_at_push;
            end
            // slot frees while the result is on the cdb
            if (retire) begin
                valid_q[sel_idx] <= 1'b0;
                sel_valid        <= 1'b0;
                rr_base          <= sel_idx + lsq_idx_t'(1);
            end else if (!sel_valid && found) begin
                sel_valid <= 1'b1;
                sel_idx   <= found_idx;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            funct3_q[free_idx]  <= dispatch.instr[14:12];
            tag_q[free_idx]     <= dispatch.tag;
            dep_ptr_q[free_idx] <= sq_status.youngest;
            ready_q[free_idx]   <= 1'b0;
        end
        for (int i = 0; i < `LSQ_DEPTH; i++) begin
            if (addr_update.valid && valid_q[i] && (tag_q[i] == addr_update.tag)) begin
                addr_q[i]  <= addr_update.addr;
                ready_q[i] <= 1'b1;
            end
        end
    end

    // held choice stays put until the load has finished
    always_comb begin
        load_cand.valid  = sel_valid;
        load_cand.addr   = addr_q[sel_idx];
        load_cand.data   = '0;
        load_cand.funct3 = funct3_q[sel_idx];
        load_cand.tag    = tag_q[sel_idx];
    end

endmodule

`default_nettype wire

// File: queue/store_queue.sv
`default_nettype none

`include "lsq_cfg.svh"

module store_queue
    import lsq_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  logic          flush,
    input  dispatch_t     dispatch,
    input  addr_update_t  addr_update,
    input  rob_tag_t      rob_commit_tag,
    input  logic          store_done,
    output logic          full,
    output mem_op_t       store_cand,
    output sq_status_t    sq_status
);

    logic [`LSQ_DEPTH-1:0] valid_q;
    logic [`LSQ_DEPTH-1:0] ready_q;
    logic [2:0]            funct3_q [`LSQ_DEPTH];
    rob_tag_t              tag_q    [`LSQ_DEPTH];
    logic [`XLEN-1:0]      addr_q   [`LSQ_DEPTH];
    logic [`XLEN-1:0]      data_q   [`LSQ_DEPTH];
    lsq_idx_t              head;
    lsq_idx_t              tail;
    logic                  push;
    logic                  pop;

    // ring is full once the tail slot is still occupied
    assign full = valid_q[tail];
    assign push = dispatch.valid && (dispatch.instr[6:0] == op_store) && !full;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            valid_q <= '0;
            head    <= '0;
            tail    <= '0;
            pop     <= 1'b0;
        end else begin
            // head leaves one cycle after the write response
            pop <= store_done;
            if (push) begin
                valid_q[tail] <= 1'b1;
                tail          <= tail + lsq_idx_t'(1);
            end
            if (pop) begin
                valid_q[head] <= 1'b0;
                head          <= head + lsq_idx_t'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            funct3_q[tail] <= dispatch.instr[14:12];
            tag_q[tail]    <= dispatch.tag;
            ready_q[tail]  <= 1'b0;
        end
        // late address and data, matched by rob tag
        for (int i = 0; i < `LSQ_DEPTH; i++) begin
            if (addr_update.valid && valid_q[i] && (tag_q[i] == addr_update.tag)) begin
                addr_q[i]  <= addr_update.addr;
                data_q[i]  <= addr_update.data;
                ready_q[i] <= 1'b1;
            end
        end
    end

    // only the committing head may go to memory
    always_comb begin
        store_cand.valid  = valid_q[head] && ready_q[head] && (tag_q[head] == rob_commit_tag);
        store_cand.addr   = addr_q[head];
        store_cand.data   = data_q[head];
        store_cand.funct3 = funct3_q[head];
        store_cand.tag    = tag_q[head];
    end

    always_comb begin
        sq_status.nonempty  = |valid_q;
        sq_status.youngest  = tail - lsq_idx_t'(1);
        sq_status.commit    = pop;
        sq_status.committed = head;
    end

endmodule

`default_nettype wire

// File: source/lsq_top.sv
`default_nettype none

`include "lsq_cfg.svh"

module lsq_top
    import lsq_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              flush,
    input  dispatch_t         dispatch,
    input  addr_update_t      addr_update,
    input  rob_tag_t          rob_commit_tag,
    input  logic [`XLEN-1:0]  mem_rdata,
    input  logic              mem_resp,
    output logic              sq_full,
    output logic              ls_full,
    output mem_req_t          mem_req,
    output cdb_t              cdb
);

    mem_op_t     store_cand;
    mem_op_t     load_cand;
    sq_status_t  sq_status;
    logic        store_done;
    logic        load_done;

    store_queue u_store_queue (
        .clk            (clk),
        .rst            (rst),
        .flush          (flush),
        .dispatch       (dispatch),
        .addr_update    (addr_update),
        .rob_commit_tag (rob_commit_tag),
        .store_done     (store_done),
        .full           (sq_full),
        .store_cand     (store_cand),
        .sq_status      (sq_status)
    );

    // loads track store commits through sq_status
    load_station u_load_station (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .dispatch    (dispatch),
        .addr_update (addr_update),
        .sq_status   (sq_status),
        .load_done   (load_done),
        .full        (ls_full),
        .load_cand   (load_cand)
    );

    mem_access_unit u_mem_access_unit (
        .clk        (clk),
        .rst        (rst),
        .flush      (flush),
        .store_cand (store_cand),
        .load_cand  (load_cand),
        .mem_rdata  (mem_rdata),
        .mem_resp   (mem_resp),
        .mem_req    (mem_req),
        .cdb        (cdb),
        .store_done (store_done),
        .load_done  (load_done)
    );

endmodule

`default_nettype wire

// File: verification/lsq_tb.sv
`default_nettype none

`include "lsq_cfg.svh"

module lsq_tb
    import lsq_pkg::*;
();

    localparam int       TIMEOUT   = 400;
    localparam int       MEM_WORDS = 256;
    localparam rob_tag_t PARK_TAG  = 3'd7;

    logic          clk;
    logic          rst;
    logic          flush;
    dispatch_t     dispatch;
    addr_update_t  addr_update;
    rob_tag_t      rob_commit_tag;
    logic [31:0]   mem_rdata;
    logic          mem_resp;
    logic          sq_full;
    logic          ls_full;
    mem_req_t      mem_req;
    cdb_t          cdb;

    logic [31:0]   mem [MEM_WORDS];
    logic [31:0]   rng;
    logic          mem_busy;
    mem_req_t      req_log [$];
    rob_tag_t      cdb_tags [$];
    logic [31:0]   cdb_data [$];
    int            mismatches;
    int            failures;

    always #20 clk = ~clk;

    lsq_top dut (
        .clk            (clk),
        .rst            (rst),
        .flush          (flush),
        .dispatch       (dispatch),
        .addr_update    (addr_update),
        .rob_commit_tag (rob_commit_tag),
        .mem_rdata      (mem_rdata),
        .mem_resp       (mem_resp),
        .sq_full        (sq_full),
        .ls_full        (ls_full),
        .mem_req        (mem_req),
        .cdb            (cdb)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // byte, half or word lanes from the low address bits
    function automatic logic [3:0] lane_mask(input logic [2:0] f3, input logic [1:0] off);
        case (f3[1:0])
            2'b00:   return 4'b0001 << off;
            2'b01:   return 4'b0011 << off;
            default: return 4'b1111;
        endcase
    endfunction

    function automatic logic [31:0] byte_lanes(input logic [3:0] mask);
        return {{8{mask[3]}}, {8{mask[2]}}, {8{mask[1]}}, {8{mask[0]}}};
    endfunction

    function automatic logic [31:0] expected_load(input logic [2:0] f3, input logic [1:0] off,
                                                  input logic [31:0] word);
        logic [31:0] shifted;
        shifted = word >> (8 * off);
        case (f3)
            3'b000:  return {{24{shifted[7]}}, shifted[7:0]};
            3'b100:  return {24'h0, shifted[7:0]};
            3'b001:  return {{16{shifted[15]}}, shifted[15:0]};
            3'b101:  return {16'h0, shifted[15:0]};
            default: return word;
        endcase
    endfunction

    // word memory with random latency that applies the masks at the response
    always begin
        mem_req_t req;
        int       latency;
        @(negedge clk);
        if (!rst && ((mem_req.rmask != '0) || (mem_req.wmask != '0))) begin
            req = mem_req;
            req_log.push_back(req);
            mem_busy = 1'b1;
            rng = xorshift(rng);
            latency = 1 + int'(rng % 4);
            repeat (latency) @(posedge clk);
            #2;
            for (int b = 0; b < 4; b++) begin
                if (req.wmask[b]) begin
                    mem[req.addr[9:2]][8*b +: 8] = req.wdata[8*b +: 8];
                end
            end
            mem_rdata = mem[req.addr[9:2]];
            mem_resp = 1'b1;
            @(posedge clk);
            #2;
            mem_resp = 1'b0;
            mem_busy = 1'b0;
        end
    end

    always @(negedge clk) begin
        if (!rst && cdb.valid) begin
            cdb_tags.push_back(cdb.tag);
            cdb_data.push_back(cdb.data);
        end
    end

    task automatic next_cycle;
        @(posedge clk);
        #2;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            mismatches++;
            $display("MISMATCH %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_condition(input logic cond, input string what);
        assert (cond) else begin
            failures++;
            $display("%s", what);
        end
    endtask

    task automatic send_dispatch(input rv_opcode_e op, input logic [2:0] f3,
                                 input rob_tag_t tag);
        dispatch.valid = 1'b1;
        dispatch.instr = {17'd0, f3, 5'd0, op};
        dispatch.tag   = tag;
        next_cycle;
        dispatch = '0;
    endtask

    task automatic send_address(input rob_tag_t tag, input logic [31:0] addr,
                                input logic [31:0] data);
        addr_update.valid = 1'b1;
        addr_update.addr  = addr;
        addr_update.data  = data;
        addr_update.tag   = tag;
        next_cycle;
        addr_update = '0;
    endtask

    task automatic wait_requests(input int count);
        int n;
        n = 0;
        while ((req_log.size() < count) && (n < TIMEOUT)) begin
            next_cycle;
            n++;
        end
        check_condition(req_log.size() >= count, "timed out waiting for a memory request");
    endtask

    task automatic wait_cdbs(input int count);
        int n;
        n = 0;
        while ((cdb_tags.size() < count) && (n < TIMEOUT)) begin
            next_cycle;
            n++;
        end
        check_condition(cdb_tags.size() >= count, "timed out waiting for a cdb broadcast");
    endtask

    task automatic wait_memory_idle;
        int n;
        n = 0;
        while (mem_busy && (n < TIMEOUT)) begin
            next_cycle;
            n++;
        end
        check_condition(!mem_busy, "timed out waiting for the memory to go idle");
    endtask

    // dispatch, address, commit, then check the write and its cdb
    task automatic do_store(input rob_tag_t tag, input store_f3_e f3,
                            input logic [31:0] addr, input logic [31:0] data);
        int          reqs;
        int          cdbs;
        logic [3:0]  mask;
        logic [31:0] lanes;
        reqs  = req_log.size();
        cdbs  = cdb_tags.size();
        mask  = lane_mask(f3, addr[1:0]);
        lanes = byte_lanes(mask);
        send_dispatch(op_store, f3, tag);
        send_address(tag, addr, data);
        rob_commit_tag = tag;
        wait_requests(reqs + 1);
        wait_cdbs(cdbs + 1);
        rob_commit_tag = PARK_TAG;
        check_value("mem_req.addr", req_log[reqs].addr, addr);
        check_value("mem_req.wmask", req_log[reqs].wmask, mask);
        check_value("mem_req.wdata", req_log[reqs].wdata & lanes,
                    (data << (8 * addr[1:0])) & lanes);
        check_value("cdb.tag", cdb_tags[cdbs], tag);
        check_value("cdb.data", cdb_data[cdbs], 32'h0);
    endtask

    task automatic do_load(input rob_tag_t tag, input load_f3_e f3,
                           input logic [31:0] addr, output logic [31:0] data);
        int reqs;
        int cdbs;
        reqs = req_log.size();
        cdbs = cdb_tags.size();
        send_dispatch(op_load, f3, tag);
        send_address(tag, addr, 32'h0);
        wait_requests(reqs + 1);
        wait_cdbs(cdbs + 1);
        check_value("mem_req.rmask", req_log[reqs].rmask, lane_mask(f3, addr[1:0]));
        check_value("cdb.tag", cdb_tags[cdbs], tag);
        data = cdb_data[cdbs];
    endtask

    task automatic test_store_load_word;
        logic [31:0] got;
        do_store(3'd1, sw, 32'h40, 32'hcafe_f00d);
        do_load(3'd2, lw, 32'h40, got);
        check_value("cdb.data", got, 32'hcafe_f00d);
    endtask

    task automatic test_sub_word;
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] got;
        for (int off = 0; off < 4; off++) begin
            addr = 32'h80 + off;
            rng  = xorshift(rng);
            data = rng;
            do_store(3'd3, sb, addr, data);
            do_load(3'd4, lb, addr, got);
            check_value("cdb.data lb", got, expected_load(lb, addr[1:0], mem[addr[9:2]]));
            do_load(3'd5, lbu, addr, got);
            check_value("cdb.data lbu", got, expected_load(lbu, addr[1:0], mem[addr[9:2]]));
        end
        for (int off = 0; off < 4; off += 2) begin
            addr = 32'h90 + off;
            rng  = xorshift(rng);
            data = rng;
            do_store(3'd3, sh, addr, data);
            do_load(3'd4, lh, addr, got);
            check_value("cdb.data lh", got, expected_load(lh, addr[1:0], mem[addr[9:2]]));
            do_load(3'd5, lhu, addr, got);
            check_value("cdb.data lhu", got, expected_load(lhu, addr[1:0], mem[addr[9:2]]));
        end
    endtask

    // younger load has its address first but must wait for the store
    task automatic test_ordering;
        int          reqs;
        int          cdbs;
        logic [31:0] data;
        reqs = req_log.size();
        cdbs = cdb_tags.size();
        rng  = xorshift(rng);
        data = rng;
        send_dispatch(op_store, sw, 3'd5);
        send_dispatch(op_load, lw, 3'd6);
        send_address(3'd6, 32'hc0, 32'h0);
        repeat (10) next_cycle;
        check_condition(req_log.size() == reqs, "a load read memory ahead of an older store");
        send_address(3'd5, 32'hc0, data);
        repeat (10) next_cycle;
        check_condition(req_log.size() == reqs, "memory was accessed before the store committed");
        rob_commit_tag = 3'd5;
        wait_cdbs(cdbs + 2);
        rob_commit_tag = PARK_TAG;
        check_condition(req_log[reqs].wmask == 4'hf, "the first access was not the store write");
        check_value("mem_req.rmask", req_log[reqs+1].rmask, 4'hf);
        check_value("cdb.tag", cdb_tags[cdbs], 3'd5);
        check_value("cdb.tag", cdb_tags[cdbs+1], 3'd6);
        check_value("cdb.data", cdb_data[cdbs+1], data);
    endtask

    task automatic test_capacity;
        logic [31:0]           data [`LSQ_DEPTH];
        logic [`LSQ_DEPTH-1:0] seen;
        rob_tag_t              tag;
        int                    cdbs;
        cdbs = cdb_tags.size();
        for (int i = 0; i < `LSQ_DEPTH; i++) begin
            send_dispatch(op_store, sw, rob_tag_t'(i));
        end
        check_value("sq_full", sq_full, 1'b1);
        // a byte store that the full queue must drop
        send_dispatch(op_store, sb, rob_tag_t'(0));
        for (int i = 0; i < `LSQ_DEPTH; i++) begin
            rng     = xorshift(rng);
            data[i] = rng;
            send_address(rob_tag_t'(i), 32'h100 + 4 * i, data[i]);
        end
        for (int i = 0; i < `LSQ_DEPTH; i++) begin
            rob_commit_tag = rob_tag_t'(i);
            wait_cdbs(cdbs + i + 1);
            check_value("cdb.tag", cdb_tags[cdbs+i], i);
        end
        rob_commit_tag = PARK_TAG;
        repeat (20) next_cycle;
        check_value("store cdb count", cdb_tags.size() - cdbs, `LSQ_DEPTH);
        check_value("sq_full", sq_full, 1'b0);

        cdbs = cdb_tags.size();
        for (int i = 0; i < `LSQ_DEPTH; i++) begin
            send_dispatch(op_load, lw, rob_tag_t'(i));
        end
        check_value("ls_full", ls_full, 1'b1);
        // a byte load that the full station must drop
        send_dispatch(op_load, lbu, rob_tag_t'(0));
        for (int i = 0; i < `LSQ_DEPTH; i++) begin
            send_address(rob_tag_t'(i), 32'h100 + 4 * i, 32'h0);
        end
        wait_cdbs(cdbs + `LSQ_DEPTH);
        repeat (20) next_cycle;
        check_value("load cdb count", cdb_tags.size() - cdbs, `LSQ_DEPTH);
        check_value("ls_full", ls_full, 1'b0);
        // loads finish in any order so they are matched by tag
        seen = '0;
        for (int j = 0; j < `LSQ_DEPTH; j++) begin
            tag = cdb_tags[cdbs+j];
            check_condition(!seen[tag], "a load tag was broadcast twice");
            seen[tag] = 1'b1;
            check_value("cdb.data", cdb_data[cdbs+j], data[tag]);
        end
    endtask

    task automatic test_flush;
        int          reqs;
        int          cdbs;
        logic [31:0] data;
        logic [31:0] got;
        reqs = req_log.size();
        cdbs = cdb_tags.size();
        send_dispatch(op_load, lw, 3'd2);
        send_address(3'd2, 32'h40, 32'h0);
        wait_requests(reqs + 1);
        flush = 1'b1;
        next_cycle;
        flush = 1'b0;
        wait_memory_idle;
        repeat (5) next_cycle;
        check_condition(cdb_tags.size() == cdbs, "a flushed load was broadcast on the cdb");
        check_value("sq_full", sq_full, 1'b0);
        check_value("ls_full", ls_full, 1'b0);
        rng  = xorshift(rng);
        data = rng;
        do_store(3'd3, sh, 32'h46, data);
        do_load(3'd4, lhu, 32'h46, got);
        check_value("cdb.data", got, {16'h0, data[15:0]});
    endtask

    initial begin
        clk            = 1'b0;
        rst            = 1'b1;
        flush          = 1'b0;
        dispatch       = '0;
        addr_update    = '0;
        rob_commit_tag = PARK_TAG;
        mem_rdata      = '0;
        mem_resp       = 1'b0;
        mem_busy       = 1'b0;
        rng            = 32'd11;
        mismatches     = 0;
        failures       = 0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = i * 32'h9e37_79b1 + 32'h1357_9bdf;
        end
        repeat (8) next_cycle;
        rst = 1'b0;

        check_value("cdb.valid", cdb.valid, 1'b0);
        check_value("mem_req.rmask", mem_req.rmask, 4'h0);
        check_value("mem_req.wmask", mem_req.wmask, 4'h0);
        check_value("sq_full", sq_full, 1'b0);
        check_value("ls_full", ls_full, 1'b0);
        check_value("store_cand.valid", dut.u_store_queue.store_cand.valid, 1'b0);
        check_value("load_cand.valid", dut.u_load_station.load_cand.valid, 1'b0);

        test_store_load_word;
        test_sub_word;
        test_ordering;
        test_capacity;
        test_flush;
        wait_memory_idle;

        $display("checks done with %0d mismatches and %0d other failures",
                 mismatches, failures);
        if ((mismatches + failures) == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire
